/* Makefile */
VERILATOR  ?= verilator
TOP        := tb_serial_regfile
FILELIST   := filelist.f
SIM_FLAGS  := --binary --timing --assert
LINT_FLAGS := --lint-only --timing --assert
BUILD_DIR  := obj_dir
LOG        := sim.log
FAIL_MSG   := Finished with errors
PASS_MSG   := Finished with no errors

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation incomplete"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* design/core_pkg.sv */
package core_pkg;

   // Command opcodes matching the test vector encoding
   typedef enum logic [2:0] {
      LOAD = 3'd0,
      ADD  = 3'd1,
      SUB  = 3'd2,
      XOR  = 3'd3,
      AND  = 3'd4,
      CSRW = 3'd5,
      TRAP = 3'd6,
      MRET = 3'd7
   } alu_op_e;

   // Sequencer FSM
   typedef enum logic [2:0] {
      IDLE, REQ, STREAM, DRAIN, DONE
   } seq_state_e;

endpackage

/* design/op_sequencer.sv */
`timescale 1ns/10ps
`include "rf_defines.svh"

module op_sequencer (
   input  logic                i_clk,
   input  logic                i_rst,
   input  logic                i_start,
   input  core_pkg::alu_op_e   i_op,
   input  rf_pkg::reg_addr_t   i_rd,
   input  logic [`RF_XLEN-1:0] i_imm,
   output logic                o_busy,
   output logic                o_done,
   output logic                o_rreq,
   input  logic                i_rgnt,
   output logic                o_wreq,
   output logic                o_active,
   output logic                o_first,
   output logic                o_imm_bit,
   output logic                o_rd_wen,
   output logic                o_csr_en,
   output logic                o_trap,
   output logic                o_mret,
   output core_pkg::alu_op_e   o_op
);

   localparam rf_pkg::bit_cnt_t LAST_BIT = rf_pkg::bit_cnt_t'(`RF_XLEN - 1);

   core_pkg::seq_state_e state;
   core_pkg::alu_op_e    op_r;
   logic                 rd_is_x0;
   logic [`RF_XLEN-1:0]  imm_r;
   rf_pkg::bit_cnt_t     cnt;

   assign o_busy   = (state != core_pkg::IDLE);
   assign o_done   = (state == core_pkg::DONE);
   assign o_rreq   = (state == core_pkg::REQ) && (cnt == 5'd0);
   assign o_active = (state == core_pkg::STREAM);
   assign o_first  = o_active && (cnt == 5'd0);

   // Write side is armed on the first stream cycle
   assign o_wreq    = o_first;
   assign o_imm_bit = imm_r[0];
   assign o_op      = op_r;

   assign o_trap   = o_busy && (op_r == core_pkg::TRAP);
   assign o_mret   = o_busy && (op_r == core_pkg::MRET);
   assign o_csr_en = o_busy && (op_r == core_pkg::CSRW);
   assign o_rd_wen = o_busy && !rd_is_x0 && !o_trap && !o_mret;

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         state <= core_pkg::IDLE;
         cnt   <= '0;
      end else begin
         cnt <= cnt + 5'd1;
         case (state)
            core_pkg::IDLE: begin
               if (i_start) begin
                  state <= core_pkg::REQ;
                  cnt   <= '0;
               end
            end
            core_pkg::REQ: begin
               if (i_rgnt) begin
                  state <= core_pkg::STREAM;
                  cnt   <= '0;
               end
            end
            core_pkg::STREAM: begin
               if (cnt == LAST_BIT) begin
                  state <= core_pkg::DRAIN;
                  cnt   <= '0;
               end
            end
            // Two cycles for the last write slots to land
            core_pkg::DRAIN: begin
               if (cnt == 5'd1) begin
                  state <= core_pkg::DONE;
               end
            end
            default: state <= core_pkg::IDLE;
         endcase
      end
   end

   // Command payload
   always_ff @(posedge i_clk) begin
      if (state == core_pkg::IDLE && i_start) begin
         op_r     <= i_op;
         rd_is_x0 <= (i_rd == '0);
         imm_r    <= i_imm;
      end else if (o_active) begin
         imm_r <= {1'b0, imm_r[`RF_XLEN-1:1]};
      end
   end

endmodule

/* design/rf_defines.svh */
`ifndef RF_DEFINES_SVH
`define RF_DEFINES_SVH

// Datapath width in bits
`define RF_XLEN 32

// General registers including x0
`define RF_NUM_REGS 32

// CSR slot indices within the CSR rows
`define RF_CSR_MSCRATCH 2'd0
`define RF_CSR_MTVEC    2'd1
`define RF_CSR_MEPC     2'd2
`define RF_CSR_MTVAL    2'd3

// 36 rows of 16 two-bit words
`define RF_RAM_DEPTH 576

`endif

/* design/rf_mpram.sv */
`timescale 1ns/10ps
`include "rf_defines.svh"

module rf_mpram (
   input  logic              i_clk,
   input  logic              i_rst,
   input  logic              i_trap,
   input  logic              i_mret,
   input  logic              i_mepc,
   input  logic              i_mtval,
   input  logic              i_csr_en,
   input  rf_pkg::csr_sel_t  i_csr_sel,
   input  logic              i_csr,
   output logic              o_csr,
   output logic              o_csr_pc,
   input  logic              i_rd_wen,
   input  rf_pkg::reg_addr_t i_rd_waddr,
   input  logic              i_rd,
   input  logic              i_wreq,
   input  logic              i_rreq,
   output logic              o_rgnt,
   input  rf_pkg::reg_addr_t i_rs1_raddr,
   input  rf_pkg::reg_addr_t i_rs2_raddr,
   output logic              o_rs1,
   output logic              o_rs2
);

   // CSR rows sit at 32..35
   localparam logic [3:0] CSR_ROW = 4'b1000;

   rf_pkg::bit_cnt_t  wcnt;
   logic              wreq_r;
   logic              wgo;
   logic [3:0]        wslot;
   logic              wport;
   logic              wd0_in, wd0_d, wd0_r;
   logic              wd1_in, wd1_d, wd1_r, wd1_2r;
   logic [5:0]        wrow0, wrow1;
   rf_pkg::ram_addr_t waddr;
   rf_pkg::ram_word_t wdata;
   logic              wen;

   rf_pkg::bit_cnt_t  rcnt;
   logic              rreq_r;
   logic [3:0]        rslot;
   logic              rport;
   logic [5:0]        rrow0, rrow1;
   rf_pkg::ram_addr_t raddr;
   rf_pkg::ram_word_t rdata;
   rf_pkg::ram_word_t rdata0;
   logic              rdata1;

   // Write side
   // port 0 carries rd or mtval, port 1 carries the CSR or mepc
   assign wslot  = wcnt[4:1];
   assign wport  = wcnt[0];
   assign wd0_in = i_trap ? i_mtval : i_rd;
   assign wd1_in = i_trap ? i_mepc : i_csr;

   // Port 1 is one slot behind port 0, hence the extra stage
   assign wdata = wport ? {wd1_r, wd1_2r} : {wd0_d, wd0_r};

   assign wrow0 = i_trap ? {CSR_ROW, `RF_CSR_MTVAL} : {1'b0, i_rd_waddr};
   assign wrow1 = i_trap ? {CSR_ROW, `RF_CSR_MEPC} : {CSR_ROW, i_csr_sel};
   assign waddr = {(wport ? wrow1 : wrow0), wslot};
   assign wen   = wgo & (i_trap | (wport ? i_csr_en : i_rd_wen));

   always_ff @(posedge i_clk) begin
      wd0_d  <= wd0_in;
      wd0_r  <= wd0_d;
      wd1_d  <= wd1_in;
      wd1_r  <= wd1_d;
      wd1_2r <= wd1_r;
   end

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         wreq_r <= 1'b0;
         wgo    <= 1'b0;
         wcnt   <= '0;
      end else begin
         wreq_r <= i_wreq;
         if (wgo) begin
            wcnt <= wcnt + 5'd1;
         end
         // Stop after the last port 1 slot
         if (wgo && wcnt == 5'd31) begin
            wgo <= 1'b0;
         end else if (wreq_r) begin
            wgo <= 1'b1;
         end
      end
   end

   // Read side
   // port 0 is rs1, port 1 is rs2 or a CSR
   assign rslot = rcnt[4:1];
   assign rport = rcnt[0];
   assign rrow0 = {1'b0, i_rs1_raddr};
   assign rrow1 = i_trap   ? {CSR_ROW, `RF_CSR_MTVEC} :
                  i_mret   ? {CSR_ROW, `RF_CSR_MEPC} :
                  i_csr_en ? {CSR_ROW, i_csr_sel} :
                             {1'b0, i_rs2_raddr};
   assign raddr = {(rport ? rrow1 : rrow0), rslot};

   // Unpack the two-bit words back into aligned serial streams
   assign o_rs1 = rport ? rdata0[1] : rdata0[0];
   assign o_rs2 = rport ? rdata1 : rdata[0];

   assign o_csr    = o_rs2 & i_csr_en;
   assign o_csr_pc = o_rs2 & (i_trap | i_mret);

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         rreq_r <= 1'b0;
         o_rgnt <= 1'b0;
         rcnt   <= '0;
      end else begin
         rreq_r <= i_rreq;
         o_rgnt <= rreq_r;
         rcnt   <= i_rreq ? 5'd0 : rcnt + 5'd1;
      end
   end

   always_ff @(posedge i_clk) begin
      if (rport) begin
         rdata0 <= rdata;
      end else begin
         rdata1 <= rdata[1];
      end
   end

   rf_ram u_ram (
      .i_clk   (i_clk),
      .i_wen   (wen),
      .i_waddr (waddr),
      .i_wdata (wdata),
      .i_raddr (raddr),
      .o_rdata (rdata)
   );

endmodule

/* design/rf_pkg.sv */
package rf_pkg;

`include "rf_defines.svh"

   // Register number x0..x31
   typedef logic [$clog2(`RF_NUM_REGS)-1:0] reg_addr_t;

   // Selects one of the four machine CSRs
   typedef logic [1:0] csr_sel_t;

   // Six bit row then four bit slot
   typedef logic [$clog2(`RF_RAM_DEPTH)-1:0] ram_addr_t;

   // Two consecutive serial bits
   typedef logic [1:0] ram_word_t;

   // Position within a 32 bit serial word
   typedef logic [4:0] bit_cnt_t;

endpackage

/* design/rf_ram.sv */
`timescale 1ns/10ps
`include "rf_defines.svh"

module rf_ram (
   input  logic              i_clk,
   input  logic              i_wen,
   input  rf_pkg::ram_addr_t i_waddr,
   input  rf_pkg::ram_word_t i_wdata,
   input  rf_pkg::ram_addr_t i_raddr,
   output rf_pkg::ram_word_t o_rdata
);

   rf_pkg::ram_word_t mem [0:`RF_RAM_DEPTH-1];

   always @(posedge i_clk) begin
      if (i_wen) begin
         mem[i_waddr] <= i_wdata;
      end
      o_rdata <= mem[i_raddr];
   end

   // Start from all zero so x0 and the CSRs read as zero
   initial begin
      for (int i = 0; i < `RF_RAM_DEPTH; i++) begin
         mem[i] = '0;
      end
   end

endmodule

/* design/serial_alu.sv */
`timescale 1ns/10ps
`include "rf_defines.svh"

module serial_alu (
   input  logic                i_clk,
   input  logic                i_rst,
   input  core_pkg::alu_op_e   i_op,
   input  logic                i_active,
   input  logic                i_first,
   input  logic                i_rs1,
   input  logic                i_rs2,
   input  logic                i_csr_old,
   input  logic                i_imm_bit,
   output logic                o_rd_bit,
   output logic                o_csr_bit,
   output logic [`RF_XLEN-1:0] o_result
);

   logic                is_sub;
   logic                carry_r;
   logic                carry_in;
   logic                op_b;
   logic                sum;
   logic                carry_out;
   logic                cap_bit;
   logic [`RF_XLEN-1:0] shreg;
   logic                act_d1, act_d2;

   // Subtract is rs1 + ~rs2 + 1
   assign is_sub    = (i_op == core_pkg::SUB);
   assign carry_in  = i_first ? is_sub : carry_r;
   assign op_b      = is_sub ? ~i_rs2 : i_rs2;
   assign sum       = i_rs1 ^ op_b ^ carry_in;
   assign carry_out = (i_rs1 & op_b) | (carry_in & (i_rs1 ^ op_b));

   always_comb begin
      case (i_op)
         core_pkg::LOAD: o_rd_bit = i_imm_bit;
         core_pkg::ADD,
         core_pkg::SUB:  o_rd_bit = sum;
         core_pkg::XOR:  o_rd_bit = i_rs1 ^ i_rs2;
         core_pkg::AND:  o_rd_bit = i_rs1 & i_rs2;
         core_pkg::CSRW: o_rd_bit = i_csr_old;
         default:        o_rd_bit = 1'b0;
      endcase
   end

   // New CSR value comes straight from rs1
   assign o_csr_bit = i_rs1;

   // Trap and mret report the CSR they read
   assign cap_bit = (i_op == core_pkg::TRAP || i_op == core_pkg::MRET) ? i_csr_old : o_rd_bit;

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         carry_r <= 1'b0;
         act_d1  <= 1'b0;
         act_d2  <= 1'b0;
      end else begin
         if (i_active) begin
            carry_r <= carry_out;
         end
         act_d1 <= i_active;
         act_d2 <= act_d1;
      end
   end

   // LSB first, so after 32 shifts bit 0 lands at the bottom
   always_ff @(posedge i_clk) begin
      if (i_active) begin
         shreg <= {cap_bit, shreg[`RF_XLEN-1:1]};
      end
      // Publish once the write drain is under way
      if (act_d2 && !act_d1) begin
         o_result <= shreg;
      end
   end

endmodule

/* design/serial_regfile_top.sv */
`timescale 1ns/10ps
`include "rf_defines.svh"

module serial_regfile_top (
   input  logic                i_clk,
   input  logic                i_rst,
   input  logic                i_start,
   input  core_pkg::alu_op_e   i_op,
   input  rf_pkg::reg_addr_t   i_rd,
   input  rf_pkg::reg_addr_t   i_rs1,
   input  rf_pkg::reg_addr_t   i_rs2,
   input  rf_pkg::csr_sel_t    i_csr_sel,
   input  logic [`RF_XLEN-1:0] i_imm,
   output logic                o_busy,
   output logic                o_done,
   output logic [`RF_XLEN-1:0] o_result
);

   rf_pkg::reg_addr_t rd_r, rs1_r, rs2_r;
   rf_pkg::csr_sel_t  csr_sel_r;
   logic              accept;

   logic              rreq, rgnt, wreq;
   logic              active, first, imm_bit;
   logic              rd_wen, csr_en, trap, mret;
   core_pkg::alu_op_e op;
   logic              rs1_bit, rs2_bit;
   logic              csr_rd_bit, csr_pc_bit, csr_old_bit;
   logic              rd_bit, csr_wr_bit;

   assign accept = i_start && !o_busy;

   // Addresses must stay stable for the whole command
   always_ff @(posedge i_clk) begin
      if (accept) begin
         rd_r      <= i_rd;
         rs1_r     <= i_rs1;
         rs2_r     <= i_rs2;
         csr_sel_r <= i_csr_sel;
      end
   end

   // At most one of the two CSR streams is live at a time
   assign csr_old_bit = csr_rd_bit | csr_pc_bit;

   op_sequencer u_seq (
      .i_clk     (i_clk),
      .i_rst     (i_rst),
      .i_start   (i_start),
      .i_op      (i_op),
      .i_rd      (i_rd),
      .i_imm     (i_imm),
      .o_busy    (o_busy),
      .o_done    (o_done),
      .o_rreq    (rreq),
      .i_rgnt    (rgnt),
      .o_wreq    (wreq),
      .o_active  (active),
      .o_first   (first),
      .o_imm_bit (imm_bit),
      .o_rd_wen  (rd_wen),
      .o_csr_en  (csr_en),
      .o_trap    (trap),
      .o_mret    (mret),
      .o_op      (op)
   );

   serial_alu u_alu (
      .i_clk     (i_clk),
      .i_rst     (i_rst),
      .i_op      (op),
      .i_active  (active),
      .i_first   (first),
      .i_rs1     (rs1_bit),
      .i_rs2     (rs2_bit),
      .i_csr_old (csr_old_bit),
      .i_imm_bit (imm_bit),
      .o_rd_bit  (rd_bit),
      .o_csr_bit (csr_wr_bit),
      .o_result  (o_result)
   );

   // Trap saves the immediate as mepc and rs1 as mtval
   rf_mpram u_rf (
      .i_clk       (i_clk),
      .i_rst       (i_rst),
      .i_trap      (trap),
      .i_mret      (mret),
      .i_mepc      (imm_bit),
      .i_mtval     (rs1_bit),
      .i_csr_en    (csr_en),
      .i_csr_sel   (csr_sel_r),
      .i_csr       (csr_wr_bit),
      .o_csr       (csr_rd_bit),
      .o_csr_pc    (csr_pc_bit),
      .i_rd_wen    (rd_wen),
      .i_rd_waddr  (rd_r),
      .i_rd        (rd_bit),
      .i_wreq      (wreq),
      .i_rreq      (rreq),
      .o_rgnt      (rgnt),
      .i_rs1_raddr (rs1_r),
      .i_rs2_raddr (rs2_r),
      .o_rs1       (rs1_bit),
      .o_rs2       (rs2_bit)
   );

endmodule

/* filelist.f */
+incdir+design
design/rf_pkg.sv
design/core_pkg.sv
design/rf_ram.sv
design/rf_mpram.sv
design/serial_alu.sv
design/op_sequencer.sv
design/serial_regfile_top.sv
tb/tb_serial_regfile.sv

/* tb/regfile_tests.txt */
// op rd rs1 rs2 csr imm expected, all hex
// op: 0 LOAD 1 ADD 2 SUB 3 XOR 4 AND 5 CSRW 6 TRAP 7 MRET; csr: 0 mscratch 1 mtvec 2 mepc 3 mtval
0 01 00 00 0 12345678 12345678
0 02 00 00 0 fedcba98 fedcba98
1 03 01 02 0 00000000 11111110
2 04 01 02 0 00000000 13579be0
3 05 01 02 0 00000000 ece8ece0
4 06 01 02 0 00000000 12141218
1 00 03 00 0 00000000 11111110
1 00 04 00 0 00000000 13579be0
1 00 05 00 0 00000000 ece8ece0
1 00 06 00 0 00000000 12141218
0 00 00 00 0 deadbeef deadbeef
1 07 00 00 0 00000000 00000000
0 08 00 00 0 cafe0001 cafe0001
5 09 08 00 0 00000000 00000000
5 0a 01 00 0 00000000 cafe0001
1 00 0a 00 0 00000000 cafe0001
0 0b 00 00 0 00000100 00000100
5 00 0b 00 1 00000000 00000000
6 00 05 00 0 80000040 00000100
7 00 00 00 0 00000000 80000040
5 0c 00 00 3 00000000 ece8ece0
2 0d 00 01 0 00000000 edcba988

/* tb/tb_serial_regfile.sv */
`timescale 1ns/10ps
`include "rf_defines.svh"

module tb_serial_regfile;

   localparam int MAX_TESTS   = 64;
   localparam int RANDOM_CMDS = 20;
   localparam int CMD_CYCLES  = 60;

   logic                i_clk;
   logic                i_rst;
   logic                i_start;
   core_pkg::alu_op_e   i_op;
   rf_pkg::reg_addr_t   i_rd, i_rs1, i_rs2;
   rf_pkg::csr_sel_t    i_csr_sel;
   logic [`RF_XLEN-1:0] i_imm;
   logic                o_busy;
   logic                o_done;
   logic [`RF_XLEN-1:0] o_result;

   // Test vectors from the data file
   logic [2:0]          vec_op  [0:MAX_TESTS-1];
   logic [4:0]          vec_rd  [0:MAX_TESTS-1];
   logic [4:0]          vec_rs1 [0:MAX_TESTS-1];
   logic [4:0]          vec_rs2 [0:MAX_TESTS-1];
   logic [1:0]          vec_csr [0:MAX_TESTS-1];
   logic [31:0]         vec_imm [0:MAX_TESTS-1];
   logic [31:0]         vec_exp [0:MAX_TESTS-1];
   int                  num_tests = 0;
   bit                  loaded = 1'b0;

   // Shadow copy of the architectural state
   logic [`RF_XLEN-1:0] regs [0:31];
   logic [`RF_XLEN-1:0] csrs [0:3];

   int                  errors = 0;
   int                  passed = 0;
   int                  done_count = 0;
   int                  dones_expected = 0;
   logic [31:0]         rnd_state;

   serial_regfile_top i_dut (
      .i_clk     (i_clk),
      .i_rst     (i_rst),
      .i_start   (i_start),
      .i_op      (i_op),
      .i_rd      (i_rd),
      .i_rs1     (i_rs1),
      .i_rs2     (i_rs2),
      .i_csr_sel (i_csr_sel),
      .i_imm     (i_imm),
      .o_busy    (o_busy),
      .o_done    (o_done),
      .o_result  (o_result)
   );

   initial begin
      i_clk = 1'b0;
      forever #5 i_clk = ~i_clk;
   end

   always @(posedge i_clk) begin
      if (o_done) begin
         done_count <= done_count + 1;
      end
   end

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] s;
      s = x ^ (x << 13);
      s = s ^ (s >> 17);
      s = s ^ (s << 5);
      return s;
   endfunction

   // Applies one command to the shadow state and returns the expected result
   task automatic apply_model(input core_pkg::alu_op_e op, input logic [4:0] rd,
                              input logic [4:0] rs1, input logic [4:0] rs2,
                              input logic [1:0] sel, input logic [31:0] imm,
                              output logic [31:0] res);
      logic [31:0] a;
      logic [31:0] b;
      a = regs[rs1];
      b = regs[rs2];
      case (op)
         core_pkg::LOAD: res = imm;
         core_pkg::ADD:  res = a + b;
         core_pkg::SUB:  res = a - b;
         core_pkg::XOR:  res = a ^ b;
         core_pkg::AND:  res = a & b;
         core_pkg::CSRW: begin
            res = csrs[sel];
            csrs[sel] = a;
         end
         core_pkg::TRAP: begin
            res = csrs[`RF_CSR_MTVEC];
            csrs[`RF_CSR_MEPC] = imm;
            csrs[`RF_CSR_MTVAL] = a;
         end
         default: res = csrs[`RF_CSR_MEPC];
      endcase
      if (rd != 5'd0 && op != core_pkg::TRAP && op != core_pkg::MRET) begin
         regs[rd] = res;
      end
   endtask

   task automatic load_tests;
      int          fd;
      int          code;
      string       line;
      logic [31:0] v_op, v_rd, v_rs1, v_rs2, v_csr, v_imm, v_exp;
      fd = $fopen("tb/regfile_tests.txt", "r");
      assert (fd != 0) else begin
         $display("Cannot open the test file tb/regfile_tests.txt");
         errors++;
      end
      if (fd != 0) begin
         while (!$feof(fd)) begin
            code = $fgets(line, fd);
            if (code == 0) begin
               break;
            end
            // Skip comments and blank lines
            if (line.len() < 2 || line.substr(0, 1) == "//") begin
               continue;
            end
            code = $sscanf(line, "%h %h %h %h %h %h %h",
                           v_op, v_rd, v_rs1, v_rs2, v_csr, v_imm, v_exp);
            if (code == 7 && num_tests < MAX_TESTS) begin
               vec_op[num_tests]  = v_op[2:0];
               vec_rd[num_tests]  = v_rd[4:0];
               vec_rs1[num_tests] = v_rs1[4:0];
               vec_rs2[num_tests] = v_rs2[4:0];
               vec_csr[num_tests] = v_csr[1:0];
               vec_imm[num_tests] = v_imm;
               vec_exp[num_tests] = v_exp;
               num_tests++;
            end
         end
         $fclose(fd);
         assert (num_tests > 0) else begin
            $display("No test vectors were read from tb/regfile_tests.txt");
            errors++;
         end
      end
      loaded = 1'b1;
   endtask

   // Issues one command and waits for o_done; noise adds start pulses while busy
   task automatic run_command(input core_pkg::alu_op_e op, input logic [4:0] rd,
                              input logic [4:0] rs1, input logic [4:0] rs2,
                              input logic [1:0] sel, input logic [31:0] imm,
                              input bit noise, output logic [31:0] res, output bit got_done);
      int cyc;
      bit busy_dropped;
      @(negedge i_clk);
      assert (done_count == dones_expected) else begin
         $display("Wrong number of o_done pulses: %0d seen, %0d expected",
                  done_count, dones_expected);
         errors++;
      end
      assert (!o_busy) else begin
         $display("DUT still busy when a new command was issued");
         errors++;
      end
      i_op         = op;
      i_rd         = rd;
      i_rs1        = rs1;
      i_rs2        = rs2;
      i_csr_sel    = sel;
      i_imm        = imm;
      i_start      = 1'b1;
      got_done     = 1'b0;
      busy_dropped = 1'b0;
      res          = '0;
      cyc          = 0;
      while (!got_done && cyc < CMD_CYCLES) begin
         @(negedge i_clk);
         cyc++;
         // Busy must stay high from acceptance through the done cycle
         if (!o_busy) begin
            busy_dropped = 1'b1;
         end
         i_start = noise && (cyc == 3 || cyc == 17);
         if (i_start) begin
            i_rd = ~rd;
         end
         if (o_done) begin
            got_done = 1'b1;
            res      = o_result;
         end
      end
      i_start = 1'b0;
      assert (!busy_dropped) else begin
         $display("o_busy was low while a %s command was still running", op.name());
         errors++;
      end
      if (got_done) begin
         dones_expected++;
      end
   endtask

   task automatic check_result(input int idx, input core_pkg::alu_op_e op,
                               input logic [31:0] res, input logic [31:0] exp,
                               input bit got_done);
      assert (got_done) else begin
         $display("Test %0d %s got no o_done within %0d cycles", idx, op.name(), CMD_CYCLES);
         errors++;
      end
      if (got_done) begin
         assert (res == exp) else begin
            $display("FAILED at %0t ns: test %0d %s returned %08h, expected %08h",
                     $time, idx, op.name(), res, exp);
            errors++;
         end
         if (res == exp) begin
            passed++;
         end
      end
      $display("Test %0d %s result %08h expected %08h", idx, op.name(), res, exp);
   endtask

   initial begin
      logic [31:0]       model_res;
      logic [31:0]       dut_res;
      bit                got_done;
      core_pkg::alu_op_e op;
      i_rst     = 1'b1;
      i_start   = 1'b0;
      i_op      = core_pkg::LOAD;
      i_rd      = '0;
      i_rs1     = '0;
      i_rs2     = '0;
      i_csr_sel = '0;
      i_imm     = '0;
      rnd_state = 32'd55;
      for (int i = 0; i < 32; i++) begin
         regs[i] = '0;
      end
      for (int i = 0; i < 4; i++) begin
         csrs[i] = '0;
      end
      load_tests();
      repeat (2) @(negedge i_clk);
      i_rst = 1'b0;

      for (int t = 0; t < num_tests; t++) begin
         op = core_pkg::alu_op_e'(vec_op[t]);
         apply_model(op, vec_rd[t], vec_rs1[t], vec_rs2[t], vec_csr[t], vec_imm[t], model_res);
         // The file value must agree with the shadow model
         assert (model_res == vec_exp[t]) else begin
            $display("Test vector %0d lists %08h but the reference model gives %08h",
                     t, vec_exp[t], model_res);
            errors++;
         end
         run_command(op, vec_rd[t], vec_rs1[t], vec_rs2[t], vec_csr[t], vec_imm[t],
                     1'b0, dut_res, got_done);
         check_result(t, op, dut_res, vec_exp[t], got_done);
      end

      // Random ADD and XOR mix with start pulses while busy
      for (int r = 0; r < RANDOM_CMDS; r++) begin
         rnd_state = xorshift32(rnd_state);
         op = rnd_state[31] ? core_pkg::XOR : core_pkg::ADD;
         apply_model(op, rnd_state[4:0], rnd_state[9:5], rnd_state[14:10], 2'd0, 32'd0,
                     model_res);
         run_command(op, rnd_state[4:0], rnd_state[9:5], rnd_state[14:10], 2'd0, 32'd0,
                     1'b1, dut_res, got_done);
         check_result(num_tests + r, op, dut_res, model_res, got_done);
      end

      repeat (4) @(negedge i_clk);
      assert (done_count == dones_expected) else begin
         $display("Wrong number of o_done pulses at the end: %0d seen, %0d expected",
                  done_count, dones_expected);
         errors++;
      end
      $display("Tests run %0d, passed %0d, errors %0d",
               num_tests + RANDOM_CMDS, passed, errors);
      if (errors == 0) begin
         $display("Finished with no errors");
      end else begin
         $display("Finished with errors");
      end
      $finish;
   end

   // Watchdog sized from the number of commands
   initial begin
      wait (loaded);
      repeat ((num_tests + RANDOM_CMDS) * CMD_CYCLES) @(posedge i_clk);
      $display("Timeout: the run did not finish within %0d cycles",
               (num_tests + RANDOM_CMDS) * CMD_CYCLES);
      $display("Finished with errors");
      $finish;
   end

endmodule
